// File: src/core_consts.svh
`ifndef CORE_CONSTS_SVH
`define CORE_CONSTS_SVH

// Datapath widths
`define XLEN       32
`define REG_ADDR_W 5
`define CAUSE_W    4

// Trap vector sits this many bytes above the boot address
`define TRAP_OFFSET 256

// Exception cause codes
`define CAUSE_ILLEGAL 2

`endif

// File: src/core_pkg.sv
`default_nettype none

`include "core_consts.svh"

package core_pkg;

  // Data word and address
  typedef logic [`XLEN-1:0] word_t;

  // Raw instruction word, always 32 bits for RV32I
  typedef logic [31:0] instr_t;

  // Register index
  typedef logic [`REG_ADDR_W-1:0] reg_addr_t;

  // Exception cause as reported on the commit port
  typedef logic [`CAUSE_W-1:0] cause_t;

  // ALU operations, branches share the unit for the compare
  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_LUI,
    ALU_BEQ,
    ALU_BNE
  } alu_op_e;

endpackage

`default_nettype wire

// File: src/fetch_stage.sv
`timescale 1ns/10ps
`default_nettype none

module fetch_stage (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  core_pkg::word_t  boot_addr_i,
  // Instruction memory, read data belongs to the address of the same cycle
  output core_pkg::word_t  imem_addr_o,
  input  core_pkg::instr_t imem_rdata_i,
  // Control
  input  logic             stall_i,
  input  logic             set_pc_i,
  input  core_pkg::word_t  pc_target_i,
  input  logic             flush_i,
  // To decode
  output logic             fetch_valid_o,
  output core_pkg::word_t  fetch_pc_o,
  output core_pkg::instr_t fetch_instr_o
);

  core_pkg::word_t pc_q;
  core_pkg::word_t pc_d;

  // Redirect wins over the stall
  always_comb begin
    pc_d = pc_q;
    if (set_pc_i) begin
      pc_d = pc_target_i;
    end else if (!stall_i) begin
      pc_d = pc_q + core_pkg::word_t'(4);
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pc_q <= boot_addr_i;
    end else begin
      pc_q <= pc_d;
    end
  end

  assign imem_addr_o = pc_q;

  // Fetch register
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      fetch_valid_o <= 1'b0;
    end else if (flush_i) begin
      fetch_valid_o <= 1'b0;
    end else if (!stall_i) begin
      fetch_valid_o <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!stall_i) begin
      fetch_pc_o    <= pc_q;
      fetch_instr_o <= imem_rdata_i;
    end
  end

endmodule

`default_nettype wire

// File: src/regfile.sv
`timescale 1ns/10ps
`default_nettype none

module regfile (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  core_pkg::reg_addr_t raddr_a_i,
  input  core_pkg::reg_addr_t raddr_b_i,
  output core_pkg::word_t     rdata_a_o,
  output core_pkg::word_t     rdata_b_o,
  input  logic                we_i,
  input  core_pkg::reg_addr_t waddr_i,
  input  core_pkg::word_t     wdata_i
);

  // x0 has no storage
  core_pkg::word_t mem_q [1:31];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 1; i < 32; i++) begin
        mem_q[i] <= '0;
      end
    end else if (we_i && waddr_i != '0) begin
      mem_q[waddr_i] <= wdata_i;
    end
  end

  assign rdata_a_o = (raddr_a_i == '0) ? '0 : mem_q[raddr_a_i];
  assign rdata_b_o = (raddr_b_i == '0) ? '0 : mem_q[raddr_b_i];

endmodule

`default_nettype wire

// File: src/decode_stage.sv
`timescale 1ns/10ps
`default_nettype none

module decode_stage (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                flush_i,
  // From fetch
  input  logic                fetch_valid_i,
  input  core_pkg::word_t     fetch_pc_i,
  input  core_pkg::instr_t    fetch_instr_i,
  // Register file read
  output core_pkg::reg_addr_t raddr_a_o,
  output core_pkg::reg_addr_t raddr_b_o,
  input  core_pkg::word_t     rdata_a_i,
  input  core_pkg::word_t     rdata_b_i,
  // Pending writes in execute and commit
  input  logic                ex_busy_i,
  input  core_pkg::reg_addr_t ex_rd_i,
  input  logic                cm_busy_i,
  input  core_pkg::reg_addr_t cm_rd_i,
  output logic                stall_o,
  // Issue register
  output logic                issue_valid_o,
  output core_pkg::word_t     issue_pc_o,
  output core_pkg::alu_op_e   issue_op_o,
  output core_pkg::reg_addr_t issue_rd_o,
  output logic                issue_we_o,
  output core_pkg::word_t     issue_a_o,
  output core_pkg::word_t     issue_b_o,
  output core_pkg::word_t     issue_imm_o,
  output logic                issue_illegal_o
);

  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;

  logic [6:0]          opcode;
  logic [2:0]          funct3;
  logic [6:0]          funct7;
  core_pkg::reg_addr_t rs1;
  core_pkg::reg_addr_t rs2;
  core_pkg::word_t     imm_i;
  core_pkg::word_t     imm_u;
  core_pkg::word_t     imm_b;
  core_pkg::alu_op_e   op_d;
  core_pkg::word_t     b_d;
  logic                we_d;
  logic                illegal_d;
  logic                use_a;
  logic                use_b;
  logic                hazard_a;
  logic                hazard_b;
  logic                issue_d;

  assign opcode = fetch_instr_i[6:0];
  assign funct3 = fetch_instr_i[14:12];
  assign funct7 = fetch_instr_i[31:25];
  assign rs1    = fetch_instr_i[19:15];
  assign rs2    = fetch_instr_i[24:20];

  assign imm_i = {{20{fetch_instr_i[31]}}, fetch_instr_i[31:20]};
  assign imm_u = {fetch_instr_i[31:12], 12'b0};
  assign imm_b = {{19{fetch_instr_i[31]}}, fetch_instr_i[31], fetch_instr_i[7],
                  fetch_instr_i[30:25], fetch_instr_i[11:8], 1'b0};

  // ------------------------------------------------------------
  // Decoder
  // ------------------------------------------------------------
  always_comb begin
    op_d      = core_pkg::ALU_ADD;
    b_d       = rdata_b_i;
    we_d      = 1'b0;
    illegal_d = 1'b0;
    use_a     = 1'b0;
    use_b     = 1'b0;
    case (opcode)
      OPC_OP: begin
        use_a = 1'b1;
        use_b = 1'b1;
        we_d  = 1'b1;
        case ({funct7, funct3})
          {7'b0000000, 3'b000}: op_d = core_pkg::ALU_ADD;
          {7'b0100000, 3'b000}: op_d = core_pkg::ALU_SUB;
          {7'b0000000, 3'b100}: op_d = core_pkg::ALU_XOR;
          {7'b0000000, 3'b110}: op_d = core_pkg::ALU_OR;
          {7'b0000000, 3'b111}: op_d = core_pkg::ALU_AND;
          default:              illegal_d = 1'b1;
        endcase
      end
      OPC_OPIMM: begin
        use_a = 1'b1;
        we_d  = 1'b1;
        b_d   = imm_i;
        case (funct3)
          3'b000:  op_d = core_pkg::ALU_ADD;
          3'b100:  op_d = core_pkg::ALU_XOR;
          3'b110:  op_d = core_pkg::ALU_OR;
          3'b111:  op_d = core_pkg::ALU_AND;
          default: illegal_d = 1'b1;
        endcase
      end
      OPC_LUI: begin
        op_d = core_pkg::ALU_LUI;
        we_d = 1'b1;
        b_d  = imm_u;
      end
      OPC_BRANCH: begin
        use_a = 1'b1;
        use_b = 1'b1;
        case (funct3)
          3'b000:  op_d = core_pkg::ALU_BEQ;
          3'b001:  op_d = core_pkg::ALU_BNE;
          default: illegal_d = 1'b1;
        endcase
      end
      default: illegal_d = 1'b1;
    endcase
    // Illegal encodings never write
    we_d = we_d & ~illegal_d;
  end

  // ------------------------------------------------------------
  // Hazard stall
  // ------------------------------------------------------------
  // No forwarding, so wait until the producer has left commit
  assign hazard_a = use_a && rs1 != '0 &&
                    ((ex_busy_i && ex_rd_i == rs1) || (cm_busy_i && cm_rd_i == rs1));
  assign hazard_b = use_b && rs2 != '0 &&
                    ((ex_busy_i && ex_rd_i == rs2) || (cm_busy_i && cm_rd_i == rs2));

  assign stall_o   = fetch_valid_i & (hazard_a | hazard_b);
  assign issue_d   = fetch_valid_i & ~stall_o & ~flush_i;
  assign raddr_a_o = rs1;
  assign raddr_b_o = rs2;

  // Issue register, the write enable only set alongside valid
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      issue_valid_o <= 1'b0;
      issue_we_o    <= 1'b0;
    end else begin
      issue_valid_o <= issue_d;
      issue_we_o    <= issue_d & we_d;
    end
  end

  always_ff @(posedge clk_i) begin
    issue_pc_o      <= fetch_pc_i;
    issue_op_o      <= op_d;
    issue_rd_o      <= fetch_instr_i[11:7];
    issue_a_o       <= rdata_a_i;
    issue_b_o       <= b_d;
    issue_imm_o     <= imm_b;
    issue_illegal_o <= illegal_d;
  end

endmodule

`default_nettype wire

// File: src/execute_stage.sv
`timescale 1ns/10ps
`default_nettype none

module execute_stage (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                flush_i,
  // Issue register
  input  logic                issue_valid_i,
  input  core_pkg::word_t     issue_pc_i,
  input  core_pkg::alu_op_e   issue_op_i,
  input  core_pkg::reg_addr_t issue_rd_i,
  input  logic                issue_we_i,
  input  core_pkg::word_t     issue_a_i,
  input  core_pkg::word_t     issue_b_i,
  input  core_pkg::word_t     issue_imm_i,
  input  logic                issue_illegal_i,
  // Branch resolution
  output logic                branch_taken_o,
  output core_pkg::word_t     branch_target_o,
  // Result register
  output logic                result_valid_o,
  output core_pkg::word_t     result_pc_o,
  output core_pkg::reg_addr_t result_rd_o,
  output logic                result_we_o,
  output core_pkg::word_t     result_data_o,
  output logic                result_illegal_o
);

  core_pkg::word_t alu_res;
  logic            operands_eq;

  assign operands_eq = (issue_a_i == issue_b_i);

  always_comb begin
    case (issue_op_i)
      core_pkg::ALU_ADD: alu_res = issue_a_i + issue_b_i;
      core_pkg::ALU_SUB: alu_res = issue_a_i - issue_b_i;
      core_pkg::ALU_AND: alu_res = issue_a_i & issue_b_i;
      core_pkg::ALU_OR:  alu_res = issue_a_i | issue_b_i;
      core_pkg::ALU_XOR: alu_res = issue_a_i ^ issue_b_i;
      core_pkg::ALU_LUI: alu_res = issue_b_i;
      default:           alu_res = '0;
    endcase
  end

  // Not-taken is the static prediction, only a taken branch redirects
  assign branch_taken_o = issue_valid_i &
                          (((issue_op_i == core_pkg::ALU_BEQ) & operands_eq) |
                           ((issue_op_i == core_pkg::ALU_BNE) & ~operands_eq));
  assign branch_target_o = issue_pc_i + issue_imm_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      result_valid_o <= 1'b0;
      result_we_o    <= 1'b0;
    end else begin
      result_valid_o <= issue_valid_i & ~flush_i;
      result_we_o    <= issue_we_i & ~flush_i;
    end
  end

  always_ff @(posedge clk_i) begin
    result_pc_o      <= issue_pc_i;
    result_rd_o      <= issue_rd_i;
    result_data_o    <= alu_res;
    result_illegal_o <= issue_illegal_i;
  end

endmodule

`default_nettype wire

// File: src/commit_stage.sv
`timescale 1ns/10ps
`default_nettype none

`include "core_consts.svh"

module commit_stage (
  // Result register
  input  logic                result_valid_i,
  input  core_pkg::word_t     result_pc_i,
  input  core_pkg::reg_addr_t result_rd_i,
  input  logic                result_we_i,
  input  core_pkg::word_t     result_data_i,
  input  logic                result_illegal_i,
  // Register file write port
  output logic                rf_we_o,
  output core_pkg::reg_addr_t rf_waddr_o,
  output core_pkg::word_t     rf_wdata_o,
  // Exception to the controller
  output logic                ex_valid_o,
  // Commit port
  output logic                commit_valid_o,
  output core_pkg::word_t     commit_pc_o,
  output logic                commit_we_o,
  output core_pkg::reg_addr_t commit_waddr_o,
  output core_pkg::word_t     commit_wdata_o,
  output logic                commit_ex_o,
  output core_pkg::cause_t    commit_cause_o
);

  // Writes to x0 are dropped here as well
  assign rf_we_o    = result_valid_i & result_we_i & ~result_illegal_i &
                      (result_rd_i != '0);
  assign rf_waddr_o = result_rd_i;
  assign rf_wdata_o = result_data_i;

  assign ex_valid_o = result_valid_i & result_illegal_i;

  assign commit_valid_o = result_valid_i;
  assign commit_pc_o    = result_pc_i;
  assign commit_we_o    = rf_we_o;
  assign commit_waddr_o = result_rd_i;
  assign commit_wdata_o = result_data_i;
  assign commit_ex_o    = ex_valid_o;
  assign commit_cause_o = result_illegal_i ? core_pkg::cause_t'(`CAUSE_ILLEGAL) : '0;

endmodule

`default_nettype wire

// File: src/controller.sv
`timescale 1ns/10ps
`default_nettype none

`include "core_consts.svh"

module controller (
  input  core_pkg::word_t boot_addr_i,
  input  logic            ex_valid_i,
  input  logic            branch_taken_i,
  input  core_pkg::word_t branch_target_i,
  output logic            set_pc_o,
  output core_pkg::word_t pc_target_o,
  output logic            flush_if_o,
  output logic            flush_id_o,
  output logic            flush_ex_o
);

  core_pkg::word_t trap_vector;

  assign trap_vector = boot_addr_i + core_pkg::word_t'(`TRAP_OFFSET);

  // Exception beats a branch resolving in the same cycle
  assign set_pc_o    = ex_valid_i | branch_taken_i;
  assign pc_target_o = ex_valid_i ? trap_vector : branch_target_i;

  // A branch kills the two younger instructions in fetch and decode
  assign flush_if_o = set_pc_o;
  assign flush_id_o = set_pc_o;
  // The execute result is only dropped on a trap
  assign flush_ex_o = ex_valid_i;

endmodule

`default_nettype wire

// File: src/core_top.sv
`timescale 1ns/10ps
`default_nettype none

module core_top (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  core_pkg::word_t     boot_addr_i,
  // Instruction memory
  output core_pkg::word_t     imem_addr_o,
  input  core_pkg::instr_t    imem_rdata_i,
  // Commit port
  output logic                commit_valid_o,
  output core_pkg::word_t     commit_pc_o,
  output logic                commit_we_o,
  output core_pkg::reg_addr_t commit_waddr_o,
  output core_pkg::word_t     commit_wdata_o,
  output logic                commit_ex_o,
  output core_pkg::cause_t    commit_cause_o
);

  // ------------------------------------------------------------
  // IF <-> ID
  // ------------------------------------------------------------
  logic                fetch_valid;
  core_pkg::word_t     fetch_pc;
  core_pkg::instr_t    fetch_instr;
  logic                stall;

  // ------------------------------------------------------------
  // ID <-> regfile, ID <-> EX
  // ------------------------------------------------------------
  core_pkg::reg_addr_t raddr_a;
  core_pkg::reg_addr_t raddr_b;
  core_pkg::word_t     rdata_a;
  core_pkg::word_t     rdata_b;
  logic                issue_valid;
  core_pkg::word_t     issue_pc;
  core_pkg::alu_op_e   issue_op;
  core_pkg::reg_addr_t issue_rd;
  logic                issue_we;
  core_pkg::word_t     issue_a;
  core_pkg::word_t     issue_b;
  core_pkg::word_t     issue_imm;
  logic                issue_illegal;

  // ------------------------------------------------------------
  // EX <-> commit, commit <-> regfile
  // ------------------------------------------------------------
  logic                result_valid;
  core_pkg::word_t     result_pc;
  core_pkg::reg_addr_t result_rd;
  logic                result_we;
  core_pkg::word_t     result_data;
  logic                result_illegal;
  logic                rf_we;
  core_pkg::reg_addr_t rf_waddr;
  core_pkg::word_t     rf_wdata;

  // ------------------------------------------------------------
  // Controller
  // ------------------------------------------------------------
  logic                branch_taken;
  core_pkg::word_t     branch_target;
  logic                ex_valid;
  logic                set_pc;
  core_pkg::word_t     pc_target;
  logic                flush_if;
  logic                flush_id;
  logic                flush_ex;

  fetch_stage i_fetch_stage (
    .clk_i         ( clk_i        ),
    .rst_ni        ( rst_ni       ),
    .boot_addr_i   ( boot_addr_i  ),
    .imem_addr_o   ( imem_addr_o  ),
    .imem_rdata_i  ( imem_rdata_i ),
    .stall_i       ( stall        ),
    .set_pc_i      ( set_pc       ),
    .pc_target_i   ( pc_target    ),
    .flush_i       ( flush_if     ),
    .fetch_valid_o ( fetch_valid  ),
    .fetch_pc_o    ( fetch_pc     ),
    .fetch_instr_o ( fetch_instr  )
  );

  // Pending write enables are only set together with their valid bits
  decode_stage i_decode_stage (
    .clk_i           ( clk_i         ),
    .rst_ni          ( rst_ni        ),
    .flush_i         ( flush_id      ),
    .fetch_valid_i   ( fetch_valid   ),
    .fetch_pc_i      ( fetch_pc      ),
    .fetch_instr_i   ( fetch_instr   ),
    .raddr_a_o       ( raddr_a       ),
    .raddr_b_o       ( raddr_b       ),
    .rdata_a_i       ( rdata_a       ),
    .rdata_b_i       ( rdata_b       ),
    .ex_busy_i       ( issue_we      ),
    .ex_rd_i         ( issue_rd      ),
    .cm_busy_i       ( result_we     ),
    .cm_rd_i         ( result_rd     ),
    .stall_o         ( stall         ),
    .issue_valid_o   ( issue_valid   ),
    .issue_pc_o      ( issue_pc      ),
    .issue_op_o      ( issue_op      ),
    .issue_rd_o      ( issue_rd      ),
    .issue_we_o      ( issue_we      ),
    .issue_a_o       ( issue_a       ),
    .issue_b_o       ( issue_b       ),
    .issue_imm_o     ( issue_imm     ),
    .issue_illegal_o ( issue_illegal )
  );

  regfile i_regfile (
    .clk_i     ( clk_i    ),
    .rst_ni    ( rst_ni   ),
    .raddr_a_i ( raddr_a  ),
    .raddr_b_i ( raddr_b  ),
    .rdata_a_o ( rdata_a  ),
    .rdata_b_o ( rdata_b  ),
    .we_i      ( rf_we    ),
    .waddr_i   ( rf_waddr ),
    .wdata_i   ( rf_wdata )
  );

  execute_stage i_execute_stage (
    .clk_i            ( clk_i          ),
    .rst_ni           ( rst_ni         ),
    .flush_i          ( flush_ex       ),
    .issue_valid_i    ( issue_valid    ),
    .issue_pc_i       ( issue_pc       ),
    .issue_op_i       ( issue_op       ),
    .issue_rd_i       ( issue_rd       ),
    .issue_we_i       ( issue_we       ),
    .issue_a_i        ( issue_a        ),
    .issue_b_i        ( issue_b        ),
    .issue_imm_i      ( issue_imm      ),
    .issue_illegal_i  ( issue_illegal  ),
    .branch_taken_o   ( branch_taken   ),
    .branch_target_o  ( branch_target  ),
    .result_valid_o   ( result_valid   ),
    .result_pc_o      ( result_pc      ),
    .result_rd_o      ( result_rd      ),
    .result_we_o      ( result_we      ),
    .result_data_o    ( result_data    ),
    .result_illegal_o ( result_illegal )
  );

  commit_stage i_commit_stage (
    .result_valid_i   ( result_valid   ),
    .result_pc_i      ( result_pc      ),
    .result_rd_i      ( result_rd      ),
    .result_we_i      ( result_we      ),
    .result_data_i    ( result_data    ),
    .result_illegal_i ( result_illegal ),
    .rf_we_o          ( rf_we          ),
    .rf_waddr_o       ( rf_waddr       ),
    .rf_wdata_o       ( rf_wdata       ),
    .ex_valid_o       ( ex_valid       ),
    .commit_valid_o   ( commit_valid_o ),
    .commit_pc_o      ( commit_pc_o    ),
    .commit_we_o      ( commit_we_o    ),
    .commit_waddr_o   ( commit_waddr_o ),
    .commit_wdata_o   ( commit_wdata_o ),
    .commit_ex_o      ( commit_ex_o    ),
    .commit_cause_o   ( commit_cause_o )
  );

  controller i_controller (
    .boot_addr_i     ( boot_addr_i   ),
    .ex_valid_i      ( ex_valid      ),
    .branch_taken_i  ( branch_taken  ),
    .branch_target_i ( branch_target ),
    .set_pc_o        ( set_pc        ),
    .pc_target_o     ( pc_target     ),
    .flush_if_o      ( flush_if      ),
    .flush_id_o      ( flush_id      ),
    .flush_ex_o      ( flush_ex      )
  );

endmodule

`default_nettype wire

// File: tb/core_assert.sv
`timescale 1ns/10ps
`default_nettype none

`include "core_consts.svh"

module core_assert (
  input logic                clk_i,
  input logic                rst_ni,
  input core_pkg::word_t     boot_addr_i,
  input core_pkg::word_t     imem_addr_o,
  input logic                commit_valid_o,
  input core_pkg::word_t     commit_pc_o,
  input logic                commit_ex_o
);

  int fail_count = 0;

  // ------------------------------------------------------------
  // Reset behavior
  // ------------------------------------------------------------
  a_no_commit_in_reset: assert property (@(posedge clk_i) !rst_ni |-> !commit_valid_o)
    else begin
      fail_count++;
      $error("commit seen while reset is active");
    end

  a_boot_fetch: assert property (@(posedge clk_i) $rose(rst_ni) |-> imem_addr_o == boot_addr_i)
    else begin
      fail_count++;
      $error("first fetch address differs from the boot address");
    end

  // ------------------------------------------------------------
  // Commit port
  // ------------------------------------------------------------
  a_pc_aligned: assert property (@(posedge clk_i) disable iff (!rst_ni)
    commit_valid_o |-> commit_pc_o[1:0] == 2'b00)
    else begin
      fail_count++;
      $error("committed PC is not word aligned");
    end

  // Trap vector shows up on the fetch address one cycle later
  a_trap_redirect: assert property (@(posedge clk_i) disable iff (!rst_ni)
    commit_ex_o |=> imem_addr_o == boot_addr_i + core_pkg::word_t'(`TRAP_OFFSET))
    else begin
      fail_count++;
      $error("fetch was not redirected to the trap vector");
    end

endmodule

bind core_top core_assert i_core_assert (.*);

`default_nettype wire

// File: tb/tb_core.sv
`timescale 1ns/10ps
`default_nettype none

`include "core_consts.svh"

module tb_core;

  localparam logic [31:0] BOOT      = 32'h0000_1000;
  localparam int          MEM_WORDS = 128;
  localparam int          RAND_LEN  = 40;
  localparam int          TRAP_IDX  = `TRAP_OFFSET / 4;
  localparam int          END_IDX   = TRAP_IDX + 6;
  localparam int          MAX_EXP   = 256;
  localparam logic [31:0] NOP       = 32'h0000_0013;

  logic                clk_i = 1'b0;
  logic                rst_ni;
  logic [31:0]         boot_addr_i;
  logic [31:0]         imem_addr_o;
  logic [31:0]         imem_rdata_i;
  logic                commit_valid_o;
  logic [31:0]         commit_pc_o;
  logic                commit_we_o;
  logic [4:0]          commit_waddr_o;
  logic [31:0]         commit_wdata_o;
  logic                commit_ex_o;
  logic [3:0]          commit_cause_o;

  logic [31:0] prog [0:MEM_WORDS-1];
  logic [31:0] imem_off;

  // Expected commit sequence
  logic [31:0] exp_pc   [0:MAX_EXP-1];
  logic        exp_we   [0:MAX_EXP-1];
  logic [4:0]  exp_rd   [0:MAX_EXP-1];
  logic [31:0] exp_data [0:MAX_EXP-1];
  logic        exp_ex   [0:MAX_EXP-1];
  int          n_exp = 0;
  int          n_seen = 0;
  int          errors = 0;
  logic        model_done = 1'b0;

  always #5 clk_i = ~clk_i;

  core_top i_dut (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .boot_addr_i    ( boot_addr_i    ),
    .imem_addr_o    ( imem_addr_o    ),
    .imem_rdata_i   ( imem_rdata_i   ),
    .commit_valid_o ( commit_valid_o ),
    .commit_pc_o    ( commit_pc_o    ),
    .commit_we_o    ( commit_we_o    ),
    .commit_waddr_o ( commit_waddr_o ),
    .commit_wdata_o ( commit_wdata_o ),
    .commit_ex_o    ( commit_ex_o    ),
    .commit_cause_o ( commit_cause_o )
  );

  // Combinational instruction memory
  assign imem_off     = imem_addr_o - BOOT;
  assign imem_rdata_i = (imem_off < 32'd512) ? prog[imem_off[8:2]] : NOP;

  // ------------------------------------------------------------
  // Encoders and LCG
  // ------------------------------------------------------------
  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd);
    return {imm, rs1, f3, rd, 7'b0010011};
  endfunction

  function automatic logic [31:0] enc_b(input logic [12:0] off, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
  endfunction

  task automatic build_program();
    logic [31:0] seed;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [11:0] imm;
    int          kind;
    seed = 32'h6fe5;
    // Unused words hold ADDI x0 with the word index as immediate
    for (int i = 0; i < MEM_WORDS; i++) begin
      prog[i] = enc_i(12'(i), 5'd0, 3'b000, 5'd0);
    end
    for (int i = 0; i < RAND_LEN; i++) begin
      seed = lcg_next(seed);
      kind = int'(seed[23:16]) % 10;
      rd   = {2'b00, seed[2:0]};
      rs1  = {2'b00, seed[5:3]};
      rs2  = {2'b00, seed[8:6]};
      imm  = {{4{seed[31]}}, seed[31:24]};
      case (kind)
        0:       prog[i] = enc_r(7'b0000000, rs2, rs1, 3'b000, rd);
        1:       prog[i] = enc_r(7'b0100000, rs2, rs1, 3'b000, rd);
        2:       prog[i] = enc_r(7'b0000000, rs2, rs1, 3'b111, rd);
        3:       prog[i] = enc_r(7'b0000000, rs2, rs1, 3'b110, rd);
        4:       prog[i] = enc_r(7'b0000000, rs2, rs1, 3'b100, rd);
        5:       prog[i] = enc_i(imm, rs1, 3'b000, rd);
        6:       prog[i] = enc_i(imm, rs1, 3'b111, rd);
        7:       prog[i] = enc_i(imm, rs1, 3'b110, rd);
        8:       prog[i] = enc_i(imm, rs1, 3'b100, rd);
        default: prog[i] = {seed[31:12], rd, 7'b0110111};
      endcase
    end
    // Branch section, taken branches skip two instructions
    prog[40] = enc_i(12'd5, 5'd0, 3'b000, 5'd1);
    prog[41] = enc_i(12'd5, 5'd0, 3'b000, 5'd2);
    prog[42] = enc_b(13'd12, 5'd2, 5'd1, 3'b000);
    prog[43] = enc_i(12'd99, 5'd0, 3'b000, 5'd3);
    prog[44] = enc_i(12'd98, 5'd0, 3'b000, 5'd3);
    prog[45] = enc_b(13'd8, 5'd2, 5'd1, 3'b001);
    prog[46] = enc_i(12'd7, 5'd0, 3'b000, 5'd4);
    prog[47] = enc_b(13'd12, 5'd4, 5'd1, 3'b001);
    prog[48] = enc_i(12'd1, 5'd0, 3'b000, 5'd5);
    prog[49] = enc_i(12'd2, 5'd0, 3'b000, 5'd5);
    prog[50] = enc_b(13'd8, 5'd4, 5'd1, 3'b000);
    prog[51] = enc_r(7'b0000000, 5'd4, 5'd1, 3'b000, 5'd6);
    prog[52] = enc_i(12'd17, 5'd0, 3'b000, 5'd0);
    prog[53] = enc_r(7'b0000000, 5'd6, 5'd0, 3'b000, 5'd7);
    prog[54] = 32'h0000_0000;
    // Trap handler
    prog[TRAP_IDX]     = enc_r(7'b0000000, 5'd0, 5'd0, 3'b000, 5'd1);
    prog[TRAP_IDX + 1] = enc_i(12'd3, 5'd1, 3'b000, 5'd2);
    prog[TRAP_IDX + 2] = enc_r(7'b0000000, 5'd6, 5'd2, 3'b100, 5'd3);
    prog[TRAP_IDX + 3] = {20'h12345, 5'd4, 7'b0110111};
    prog[TRAP_IDX + 4] = enc_r(7'b0000000, 5'd3, 5'd4, 3'b110, 5'd5);
    prog[TRAP_IDX + 5] = enc_r(7'b0100000, 5'd2, 5'd5, 3'b000, 5'd6);
  endtask

  // ------------------------------------------------------------
  // ISA reference model
  // ------------------------------------------------------------
  task automatic run_model();
    logic [31:0] rf [0:31];
    logic [31:0] pc;
    logic [31:0] instr;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] immi;
    logic [31:0] immb;
    logic [31:0] res;
    logic [31:0] next_pc;
    logic [4:0]  rd;
    logic        wr;
    logic        ex;
    for (int i = 0; i < 32; i++) begin
      rf[i] = 32'd0;
    end
    pc = BOOT;
    while (pc != BOOT + 32'(END_IDX * 4) && n_exp < MAX_EXP) begin
      instr   = prog[int'((pc - BOOT) >> 2)];
      rd      = instr[11:7];
      a       = rf[instr[19:15]];
      b       = rf[instr[24:20]];
      immi    = {{20{instr[31]}}, instr[31:20]};
      immb    = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
      res     = 32'd0;
      wr      = 1'b0;
      ex      = 1'b0;
      next_pc = pc + 32'd4;
      case (instr[6:0])
        7'b0110011: begin
          wr = 1'b1;
          case ({instr[31:25], instr[14:12]})
            10'b0000000_000: res = a + b;
            10'b0100000_000: res = a - b;
            10'b0000000_111: res = a & b;
            10'b0000000_110: res = a | b;
            10'b0000000_100: res = a ^ b;
            default:         ex = 1'b1;
          endcase
        end
        7'b0010011: begin
          wr = 1'b1;
          case (instr[14:12])
            3'b000:  res = a + immi;
            3'b111:  res = a & immi;
            3'b110:  res = a | immi;
            3'b100:  res = a ^ immi;
            default: ex = 1'b1;
          endcase
        end
        7'b0110111: begin
          wr  = 1'b1;
          res = {instr[31:12], 12'b0};
        end
        7'b1100011: begin
          case (instr[14:12])
            3'b000:  if (a == b) next_pc = pc + immb;
            3'b001:  if (a != b) next_pc = pc + immb;
            default: ex = 1'b1;
          endcase
        end
        default: ex = 1'b1;
      endcase
      if (ex) begin
        wr      = 1'b0;
        next_pc = BOOT + 32'(`TRAP_OFFSET);
      end
      exp_pc[n_exp]   = pc;
      exp_we[n_exp]   = wr && rd != 5'd0;
      exp_rd[n_exp]   = rd;
      exp_data[n_exp] = res;
      exp_ex[n_exp]   = ex;
      if (wr && rd != 5'd0) begin
        rf[rd] = res;
      end
      n_exp++;
      pc = next_pc;
    end
  endtask

  // ------------------------------------------------------------
  // Commit checks
  // ------------------------------------------------------------
  task automatic report_mismatch(input string name, input logic [31:0] exp_v,
                                 input logic [31:0] act_v);
    $display("ERR %s: expected %h, actual %h", name, exp_v, act_v);
    errors++;
  endtask

  task automatic check_commit(input int k);
    assert (commit_pc_o == exp_pc[k])
      else report_mismatch($sformatf("commit %0d pc", k), exp_pc[k], commit_pc_o);
    assert (commit_ex_o == exp_ex[k])
      else report_mismatch($sformatf("commit %0d ex", k), 32'(exp_ex[k]), 32'(commit_ex_o));
    assert (commit_we_o == exp_we[k])
      else report_mismatch($sformatf("commit %0d we", k), 32'(exp_we[k]), 32'(commit_we_o));
    if (exp_we[k]) begin
      assert (commit_waddr_o == exp_rd[k])
        else report_mismatch($sformatf("commit %0d rd", k), 32'(exp_rd[k]),
                             32'(commit_waddr_o));
      assert (commit_wdata_o == exp_data[k])
        else report_mismatch($sformatf("commit %0d data", k), exp_data[k], commit_wdata_o);
    end
    if (exp_ex[k]) begin
      assert (commit_cause_o == 4'(`CAUSE_ILLEGAL))
        else report_mismatch($sformatf("commit %0d cause", k), 32'(`CAUSE_ILLEGAL),
                             32'(commit_cause_o));
    end
  endtask

  // Outputs are stable at the falling edge
  always @(negedge clk_i) begin
    if (rst_ni === 1'b1 && commit_valid_o && model_done) begin
      if (n_seen < n_exp) begin
        check_commit(n_seen);
      end
      n_seen++;
    end
  end

  // Watchdog scaled to the expected commit count
  initial begin
    wait (model_done);
    repeat (n_exp * 8 + 20) @(posedge clk_i);
    $display("Timeout: only %0d of %0d commits seen", n_seen, n_exp);
    $display("Something failed");
    $finish;
  end

  initial begin
    rst_ni      = 1'b0;
    boot_addr_i = BOOT;
    build_program();
    run_model();
    model_done = 1'b1;
    repeat (5) @(posedge clk_i);
    #1 rst_ni = 1'b1;
    while (n_seen < n_exp) begin
      @(posedge clk_i);
    end
    repeat (5) @(posedge clk_i);
    errors = errors + i_dut.i_core_assert.fail_count;
    $display("Done: %0d errors in %0d of %0d commits", errors, n_seen, n_exp);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+src
src/core_pkg.sv
src/fetch_stage.sv
src/regfile.sv
src/decode_stage.sv
src/execute_stage.sv
src/commit_stage.sv
src/controller.sv
src/core_top.sv
tb/core_assert.sv
tb/tb_core.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --assert --timing --top-module tb_core -f verilog.f -o Vtb_core
	./obj_dir/Vtb_core | tee sim.log
	grep -q "Everything OK" sim.log

clean:
	rm -rf obj_dir sim.log
